// File: serdes_rx_defs.svh
/*
 * Build-time constants for the serial receive front end.
 * Include wherever word width, register map or reset values are needed.
 */

`ifndef SERDES_RX_DEFS_SVH
`define SERDES_RX_DEFS_SVH

// **************************************************
// Datapath
// **************************************************
`define SERDES_RX_WIDTH        8      // Bits per received word
`define SERDES_RX_ALIGN_HITS   3      // Consecutive matches to declare alignment

// **************************************************
// Register map, 2-bit address space
// **************************************************
`define SERDES_RX_ADDR_CTRL    2'd0   // bit0 enable, bit1 align_en
`define SERDES_RX_ADDR_PATTERN 2'd1   // Training pattern
`define SERDES_RX_ADDR_WAIT    2'd2   // Lock wait count
`define SERDES_RX_ADDR_STATUS  2'd3   // Read only

// Reset values
`define SERDES_RX_PATTERN_RST  8'hA5  // Default training word
`define SERDES_RX_WAIT_RST     8'd16  // Default PLL settle cycles

`endif

// File: serdes_rx_pkg.sv
/*
 * Shared types of the serial receive front end.
 * Modules refer to these by scoped name, serdes_rx_pkg::<type>.
 */

`include "serdes_rx_defs.svh"

package serdes_rx_pkg;

    // **************************************************
    // Datapath word
    // **************************************************
    typedef logic [`SERDES_RX_WIDTH-1:0] rx_word_t;  // One deserialized word

    // **************************************************
    // Configuration and status
    // **************************************************
    typedef struct packed {
        logic       enable;     // Sample serial input
        logic       align_en;   // Hunt for training pattern
        rx_word_t   pattern;    // Training word
        logic [7:0] lock_wait;  // Cycles to wait after PLL lock
    } rx_cfg_t;

    // Packs as {locked, aligned, drop_count} in the status register
    typedef struct packed {
        logic       locked;     // From lock sequencer
        logic       aligned;    // From word aligner
        logic [7:0] drop_count; // From skid buffer, saturating
    } rx_status_t;

    // **************************************************
    // Configuration request
    // **************************************************
    typedef struct packed {
        logic        write;     // 1 write, 0 read
        logic [1:0]  addr;      // Register select
        logic [15:0] wdata;     // Write payload
    } cfg_req_t;

endpackage

// File: rx_deserializer.sv
/*
 * Serial to parallel converter, MSB first.
 * Emits one word strobe every WIDTH enabled cycles; a bitslip pulse
 * stretches the current word by one bit to move the word boundary.
 */

`timescale 1ns/1ps
`include "serdes_rx_defs.svh"

module rx_deserializer (
    input  logic                    fabric_clk_div,
    input  logic                    reset_buf_n,
    input  logic                    serial_data,
    input  serdes_rx_pkg::rx_cfg_t  cfg,
    input  logic                    bitslip,
    output serdes_rx_pkg::rx_word_t word,
    output logic                    word_valid
);

    localparam int W     = `SERDES_RX_WIDTH;
    localparam int CNT_W = $clog2(W);

    logic [W-1:0]     shift_q;     // Incoming bits, newest in LSB
    logic [CNT_W-1:0] bit_cnt;     // Bits collected in current word
    logic             last_bit;    // Current sample completes a word

    assign last_bit = (bit_cnt == CNT_W'(W - 1)) && !bitslip;

    // **************************************************
    // Shift register
    // **************************************************
    always_ff @(posedge fabric_clk_div) begin
        if (cfg.enable) begin
            shift_q <= {shift_q[W-2:0], serial_data};  // MSB arrives first
        end
    end

    // Word is whole in the cycle after the last bit is sampled
    assign word = shift_q;

    // **************************************************
    // Bit counter and word strobe
    // **************************************************
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            bit_cnt    <= '0;
            word_valid <= 1'b0;
        end else begin
            word_valid <= 1'b0;                   // Single-cycle strobe
            if (!cfg.enable) begin
                bit_cnt <= '0;                    // Restart on word boundary
            end else if (bitslip) begin
                bit_cnt <= bit_cnt;               // Slip, bit shifts but not counted
            end else if (last_bit) begin
                bit_cnt    <= '0;
                word_valid <= 1'b1;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // Aligner answers a strobe one cycle later, never on top of one
    a_no_slip_on_word: assert property (
        @(posedge fabric_clk_div) disable iff (!reset_buf_n)
        !(bitslip && word_valid)
    );

endmodule

// File: rx_word_aligner.sv
/*
 * Word aligner and forwarding gate.
 * While hunting, compares each word to the training pattern and requests
 * a bitslip on mismatch; after enough hits declares alignment.
 * Data words go onward only when locked and aligned (or alignment is off).
 */

`timescale 1ns/1ps
`include "serdes_rx_defs.svh"

module rx_word_aligner (
    input  logic                    fabric_clk_div,
    input  logic                    reset_buf_n,
    input  serdes_rx_pkg::rx_word_t word,
    input  logic                    word_valid,
    input  serdes_rx_pkg::rx_cfg_t  cfg,
    input  logic                    locked,
    output logic                    bitslip,
    output logic                    aligned,
    output serdes_rx_pkg::rx_word_t fwd_word,
    output logic                    fwd_valid
);

    localparam int HITS  = `SERDES_RX_ALIGN_HITS;
    localparam int HIT_W = $clog2(HITS + 1);

    logic [HIT_W-1:0] hit_cnt;   // Consecutive pattern matches
    logic             match;     // Word equals training pattern
    logic             seeking;   // Alignment hunt in progress
    logic             pass;      // Forwarding allowed

    assign match   = (word == cfg.pattern);
    assign seeking = cfg.align_en && !aligned;
    assign pass    = locked && (aligned || !cfg.align_en);

    // **************************************************
    // Hunt state and strobes
    // **************************************************
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            hit_cnt   <= '0;
            aligned   <= 1'b0;
            bitslip   <= 1'b0;
            fwd_valid <= 1'b0;
        end else begin
            bitslip   <= 1'b0;                    // Pulses only
            fwd_valid <= 1'b0;
            if (!cfg.align_en) begin
                aligned <= 1'b0;                  // Drop lock on disable
                hit_cnt <= '0;
            end
            if (word_valid) begin
                if (seeking) begin
                    if (match) begin
                        hit_cnt <= hit_cnt + 1'b1;
                        if (hit_cnt == HIT_W'(HITS - 1)) begin
                            aligned <= 1'b1;      // Final hit
                        end
                    end else begin
                        hit_cnt <= '0;            // Start over
                        bitslip <= 1'b1;          // Shift boundary by one bit
                    end
                end else begin
                    fwd_valid <= pass;
                end
            end
        end
    end

    // Payload, no reset needed
    always_ff @(posedge fabric_clk_div) begin
        if (word_valid && !seeking && pass) begin
            fwd_word <= word;
        end
    end

    // A slip never coincides with or leads straight into alignment
    a_slip_only_unaligned: assert property (
        @(posedge fabric_clk_div) disable iff (!reset_buf_n)
        bitslip |-> !aligned ##1 !aligned
    );

endmodule

// File: rx_lock_sequencer.sv
/*
 * PLL lock qualifier.
 * Raises locked lock_wait+1 cycles after pll_lock is first seen high,
 * drops it on the edge after pll_lock falls.
 */

`timescale 1ns/1ps

module rx_lock_sequencer (
    input  logic                   fabric_clk_div,
    input  logic                   reset_buf_n,
    input  logic                   pll_lock,
    input  serdes_rx_pkg::rx_cfg_t cfg,
    output logic                   locked
);

    logic [7:0] wait_cnt;    // Cycles since lock seen
    logic       wait_done;   // Count reached lock_wait

    // **************************************************
    // Settle counter
    // **************************************************
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            wait_cnt  <= '0;
            wait_done <= 1'b0;
            locked    <= 1'b0;
        end else if (!pll_lock) begin
            wait_cnt  <= '0;                      // Restart on loss of lock
            wait_done <= 1'b0;
            locked    <= 1'b0;
        end else begin
            if (wait_cnt < cfg.lock_wait) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
            wait_done <= (wait_cnt >= cfg.lock_wait);  // Saturates at target
            locked    <= wait_done;                    // Extra stage, +1 cycle
        end
    end

endmodule

// File: rx_config_regs.sv
/*
 * Configuration and status registers beside the receive datapath.
 * One valid/ready request per cycle, read data one cycle later.
 * Status is sampled live at the read; status writes are ignored.
 */

`timescale 1ns/1ps
`include "serdes_rx_defs.svh"

module rx_config_regs (
    input  logic                      fabric_clk_div,
    input  logic                      reset_buf_n,
    input  serdes_rx_pkg::cfg_req_t   cfg_req,
    input  logic                      cfg_req_valid,
    input  serdes_rx_pkg::rx_status_t status,
    output logic                      cfg_req_ready,
    output logic                      cfg_rsp_valid,
    output logic [15:0]               cfg_rsp_data,
    output serdes_rx_pkg::rx_cfg_t    cfg
);

    logic accept;      // Handshake this cycle
    logic [15:0] rd_mux;  // Selected read value

    assign accept = cfg_req_valid && cfg_req_ready;

    always_comb begin
        case (cfg_req.addr)
            `SERDES_RX_ADDR_CTRL:    rd_mux = {14'd0, cfg.align_en, cfg.enable};
            `SERDES_RX_ADDR_PATTERN: rd_mux = 16'(cfg.pattern);
            `SERDES_RX_ADDR_WAIT:    rd_mux = {8'd0, cfg.lock_wait};
            default:                 rd_mux = 16'(status);  // Live status
        endcase
    end

    // **************************************************
    // Control registers
    // **************************************************
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            cfg_req_ready <= 1'b0;
            cfg_rsp_valid <= 1'b0;
            cfg.enable    <= 1'b0;
            cfg.align_en  <= 1'b0;
            cfg.pattern   <= `SERDES_RX_PATTERN_RST;
            cfg.lock_wait <= `SERDES_RX_WAIT_RST;
        end else begin
            cfg_req_ready <= 1'b1;                    // Up from first cycle out of reset
            cfg_rsp_valid <= accept && !cfg_req.write;
            if (accept && cfg_req.write) begin
                case (cfg_req.addr)
                    `SERDES_RX_ADDR_CTRL: begin
                        cfg.enable   <= cfg_req.wdata[0];
                        cfg.align_en <= cfg_req.wdata[1];
                    end
                    `SERDES_RX_ADDR_PATTERN: cfg.pattern   <= cfg_req.wdata[$bits(cfg.pattern)-1:0];
                    `SERDES_RX_ADDR_WAIT:    cfg.lock_wait <= cfg_req.wdata[7:0];
                    default: ;                        // Status is read only
                endcase
            end
        end
    end

    // Read data register
    always_ff @(posedge fabric_clk_div) begin
        if (accept && !cfg_req.write) begin
            cfg_rsp_data <= rd_mux;
        end
    end

    a_rsp_after_read: assert property (
        @(posedge fabric_clk_div) disable iff (!reset_buf_n)
        cfg_rsp_valid |-> $past(cfg_req_valid && cfg_req_ready && !cfg_req.write)
    );

endmodule

// File: rx_skid_buffer.sv
/*
 * Two-entry valid/ready output buffer, order preserving.
 * The input side has no ready; items arriving with both entries full
 * and no pop are dropped and counted (saturating at 255).
 */

`timescale 1ns/1ps

module rx_skid_buffer #(
    parameter type payload_t = logic [7:0]
) (
    input  logic       fabric_clk_div,
    input  logic       reset_buf_n,
    input  payload_t   in_data,
    input  logic       in_valid,
    input  logic       out_ready,
    output payload_t   out_data,
    output logic       out_valid,
    output logic [7:0] drop_count
);

    payload_t skid_data;     // Second entry
    logic     skid_valid;
    logic     pop;           // Head leaves this cycle
    logic     load_in;       // Input goes straight to head
    logic     load_skid;     // Skid entry moves to head
    logic     park;          // Input goes to skid entry
    logic     drop;          // Input lost

    assign pop       = out_valid && out_ready;
    assign load_skid = pop && skid_valid;
    assign load_in   = in_valid && (!out_valid || (pop && !skid_valid));
    assign park      = in_valid && out_valid && (pop ? skid_valid : !skid_valid);
    assign drop      = in_valid && out_valid && skid_valid && !pop;

    // **************************************************
    // Occupancy and drop counter
    // **************************************************
    always_ff @(posedge fabric_clk_div or negedge reset_buf_n) begin
        if (!reset_buf_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
            drop_count <= '0;
        end else begin
            if (load_in || load_skid) begin
                out_valid <= 1'b1;
            end else if (pop) begin
                out_valid <= 1'b0;                 // Drained
            end
            if (park) begin
                skid_valid <= 1'b1;
            end else if (load_skid) begin
                skid_valid <= 1'b0;
            end
            if (drop && drop_count != 8'hFF) begin
                drop_count <= drop_count + 1'b1;   // Saturate
            end
        end
    end

    // Payload registers
    always_ff @(posedge fabric_clk_div) begin
        if (load_skid) begin
            out_data <= skid_data;                 // Older item first
        end else if (load_in) begin
            out_data <= in_data;
        end
        if (park) begin
            skid_data <= in_data;
        end
    end

    a_stable_when_stalled: assert property (
        @(posedge fabric_clk_div) disable iff (!reset_buf_n)
        out_valid && !out_ready |=> out_valid && $stable(out_data)
    );

endmodule

// File: serdes_rx_top.sv
/*
 * Serial receive front end, top level.
 * Deserializer, aligner and skid buffer in line, with the lock
 * sequencer and register block alongside.
 */

`timescale 1ns/1ps

module serdes_rx_top (
    input  logic                    fabric_clk_div,
    input  logic                    reset_buf_n,
    input  logic                    serial_data,
    input  logic                    pll_lock,
    input  serdes_rx_pkg::cfg_req_t cfg_req,
    input  logic                    cfg_req_valid,
    input  logic                    out_ready,
    output logic                    cfg_req_ready,
    output logic                    cfg_rsp_valid,
    output logic [15:0]             cfg_rsp_data,
    output serdes_rx_pkg::rx_word_t out_data,
    output logic                    out_valid
);

    serdes_rx_pkg::rx_cfg_t    cfg;         // From register block
    serdes_rx_pkg::rx_status_t status;      // Back to register block
    serdes_rx_pkg::rx_word_t   word;        // Deserializer out
    serdes_rx_pkg::rx_word_t   fwd_word;    // Aligner out
    logic                      word_valid;
    logic                      fwd_valid;
    logic                      bitslip;
    logic                      locked;
    logic                      aligned;
    logic [7:0]                drop_count;

    assign status = '{locked: locked, aligned: aligned, drop_count: drop_count};

    // **************************************************
    // Datapath
    // **************************************************
    rx_deserializer rx_deserializer_i (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .serial_data    (serial_data),
        .cfg            (cfg),
        .bitslip        (bitslip),
        .word           (word),
        .word_valid     (word_valid)
    );

    rx_word_aligner rx_word_aligner_i (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .word           (word),
        .word_valid     (word_valid),
        .cfg            (cfg),
        .locked         (locked),
        .bitslip        (bitslip),
        .aligned        (aligned),
        .fwd_word       (fwd_word),
        .fwd_valid      (fwd_valid)
    );

    rx_skid_buffer #(
        .payload_t (serdes_rx_pkg::rx_word_t)
    ) rx_skid_buffer_i (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .in_data        (fwd_word),
        .in_valid       (fwd_valid),
        .out_ready      (out_ready),
        .out_data       (out_data),
        .out_valid      (out_valid),
        .drop_count     (drop_count)
    );

    // **************************************************
    // Control side
    // **************************************************
    rx_lock_sequencer rx_lock_sequencer_i (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .pll_lock       (pll_lock),
        .cfg            (cfg),
        .locked         (locked)
    );

    rx_config_regs rx_config_regs_i (
        .fabric_clk_div (fabric_clk_div),
        .reset_buf_n    (reset_buf_n),
        .cfg_req        (cfg_req),
        .cfg_req_valid  (cfg_req_valid),
        .status         (status),
        .cfg_req_ready  (cfg_req_ready),
        .cfg_rsp_valid  (cfg_rsp_valid),
        .cfg_rsp_data   (cfg_rsp_data),
        .cfg            (cfg)
    );

endmodule

// File: tb_serdes_rx.sv
/*
 * Directed testbench for the serial receive front end.
 * Drives serial bits and register requests on the falling clock edge and
 * compares the words taken at the output port, in order, with the words sent.
 */

`timescale 1ns/1ps
`include "serdes_rx_defs.svh"

module tb_serdes_rx;

    localparam int TIMEOUT     = 400;                 // Cycles allowed per wait
    localparam int LOCKED_BIT  = 9;                   // Status word {locked, aligned, drops}
    localparam int ALIGNED_BIT = 8;

    logic                    fabric_clk_div;
    logic                    reset_buf_n;
    logic                    serial_data;
    logic                    pll_lock;
    serdes_rx_pkg::cfg_req_t cfg_req;
    logic                    cfg_req_valid;
    logic                    out_ready;
    logic                    cfg_req_ready;
    logic                    cfg_rsp_valid;
    logic [15:0]             cfg_rsp_data;
    serdes_rx_pkg::rx_word_t out_data;
    logic                    out_valid;

    serdes_rx_pkg::rx_word_t exp_q[$];                // Words sent, oldest first
    serdes_rx_pkg::rx_word_t rx_q[$];                 // Words taken at the output
    logic                    skip_pattern;            // Ignore training words at output
    logic                    ready_random;            // Toggle out_ready while sending
    int                      drive_cycle;

    serdes_rx_top serdes_rx_top_i (.*);               // Port names match one to one

    initial begin
        fabric_clk_div = 1'b0;
        forever #2 fabric_clk_div = ~fabric_clk_div;  // 4 ns period
    end

    // A word moves on the rising edge where valid and ready are both high
    always @(posedge fabric_clk_div) begin
        if (reset_buf_n && out_valid && out_ready) begin
            if (!(skip_pattern && out_data == `SERDES_RX_PATTERN_RST)) begin
                rx_q.push_back(out_data);
            end
        end
    end

    // **************************************************
    // Checking and port helpers
    // **************************************************
    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("ERR %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t ns while waiting for %s", $time, what);
        $display("TEST FAILED");
        $fatal(1, "wait timed out");
    endtask

    task automatic apply_reset();
        reset_buf_n = 1'b0;
        repeat (16) @(negedge fabric_clk_div);
        reset_buf_n = 1'b1;                           // Released on a falling edge
        exp_q.delete();
        rx_q.delete();
    endtask

    task automatic wait_cfg_ready();
        int cnt;
        cnt = 0;
        while (!cfg_req_ready && cnt < TIMEOUT) begin
            @(negedge fabric_clk_div);
            cnt++;
        end
        if (!cfg_req_ready) begin
            report_timeout("register port ready");
        end
    endtask

    task automatic cfg_write(input logic [1:0] addr, input logic [15:0] wdata);
        wait_cfg_ready();
        cfg_req       = '{write: 1'b1, addr: addr, wdata: wdata};
        cfg_req_valid = 1'b1;
        @(negedge fabric_clk_div);                    // Taken on the edge in between
        cfg_req_valid = 1'b0;
    endtask

    task automatic cfg_read(input logic [1:0] addr, output logic [15:0] rdata);
        int cnt;
        wait_cfg_ready();
        cfg_req       = '{write: 1'b0, addr: addr, wdata: 16'd0};
        cfg_req_valid = 1'b1;
        @(negedge fabric_clk_div);
        cfg_req_valid = 1'b0;
        cnt = 0;
        while (!cfg_rsp_valid && cnt < TIMEOUT) begin
            @(negedge fabric_clk_div);
            cnt++;
        end
        if (!cfg_rsp_valid) begin
            report_timeout("read response");
        end else begin
            rdata = cfg_rsp_data;
        end
    endtask

    task automatic send_bit(input logic b);
        serial_data = b;
        if (ready_random) begin
            out_ready = (drive_cycle % 4 == 0) ? 1'b1 : 1'($urandom);  // High every 4th cycle
            drive_cycle++;
        end
        @(negedge fabric_clk_div);                    // Sampled on the edge in between
    endtask

    task automatic send_word(input serdes_rx_pkg::rx_word_t w);
        int i;
        for (i = `SERDES_RX_WIDTH - 1; i >= 0; i--) begin
            send_bit(w[i]);                           // MSB first
        end
    endtask

    task automatic wait_locked();
        logic [15:0] rd;
        int cnt;
        pll_lock = 1'b1;
        rd = '0;
        cnt = 0;
        while (!rd[LOCKED_BIT] && cnt < TIMEOUT) begin
            cfg_read(`SERDES_RX_ADDR_STATUS, rd);
            cnt++;
        end
        check_eq(32'(rd[LOCKED_BIT]), 1, "locked before datapath tests");
    endtask

    // Waits for every expected word, then looks for extras
    task automatic compare_stream();
        int cnt;
        int n;
        n = exp_q.size();
        cnt = 0;
        while (rx_q.size() < n && cnt < TIMEOUT) begin
            @(negedge fabric_clk_div);
            cnt++;
        end
        if (rx_q.size() < n) begin
            report_timeout("output words");
        end else begin
            repeat (4) @(negedge fabric_clk_div);
            check_eq(rx_q.size(), n, "number of output words");
            while (exp_q.size() > 0) begin
                check_eq(32'(rx_q.pop_front()), 32'(exp_q.pop_front()), "output word");
            end
        end
    endtask

    // **************************************************
    // Tests
    // **************************************************
    task automatic lock_timing_test();
        logic [15:0] rd;
        int cnt;
        check_eq(32'(out_valid), 0, "out_valid after reset");
        check_eq(32'(cfg_rsp_valid), 0, "cfg_rsp_valid after reset");
        cfg_read(`SERDES_RX_ADDR_STATUS, rd);
        check_eq(32'(rd[LOCKED_BIT:ALIGNED_BIT]), 0, "locked and aligned after reset");
        cfg_write(`SERDES_RX_ADDR_WAIT, 16'd20);
        pll_lock = 1'b1;
        @(negedge fabric_clk_div);                    // Past the first edge seeing lock
        cnt = 0;
        while (!serdes_rx_top_i.locked && cnt < TIMEOUT) begin
            @(negedge fabric_clk_div);
            cnt++;
        end
        check_eq(cnt, 21, "cycles from pll_lock to locked");
        cfg_read(`SERDES_RX_ADDR_STATUS, rd);
        check_eq(32'(rd[LOCKED_BIT]), 1, "locked status bit");
        pll_lock = 1'b0;
        @(negedge fabric_clk_div);
        check_eq(32'(serdes_rx_top_i.locked), 0, "locked one cycle after pll_lock fell");
        cfg_read(`SERDES_RX_ADDR_STATUS, rd);
        check_eq(32'(rd[LOCKED_BIT]), 0, "locked status bit after loss");
    endtask

    task automatic register_access_test();
        logic [15:0] rd;
        pll_lock = 1'b0;
        apply_reset();
        cfg_read(`SERDES_RX_ADDR_CTRL, rd);
        check_eq(32'(rd), 0, "control reset value");
        cfg_read(`SERDES_RX_ADDR_PATTERN, rd);
        check_eq(32'(rd), 32'(`SERDES_RX_PATTERN_RST), "pattern reset value");
        cfg_read(`SERDES_RX_ADDR_WAIT, rd);
        check_eq(32'(rd), 32'(`SERDES_RX_WAIT_RST), "lock wait reset value");
        cfg_write(`SERDES_RX_ADDR_PATTERN, 16'h003C);
        cfg_write(`SERDES_RX_ADDR_WAIT, 16'h0055);
        cfg_write(`SERDES_RX_ADDR_CTRL, 16'h0002);    // align_en only, datapath idle
        cfg_write(`SERDES_RX_ADDR_STATUS, 16'hFFFF);  // Read only, no effect
        cfg_read(`SERDES_RX_ADDR_PATTERN, rd);
        check_eq(32'(rd), 32'h3C, "pattern readback");
        cfg_read(`SERDES_RX_ADDR_WAIT, rd);
        check_eq(32'(rd), 32'h55, "lock wait readback");
        cfg_read(`SERDES_RX_ADDR_CTRL, rd);
        check_eq(32'(rd), 32'h2, "control readback");
        cfg_read(`SERDES_RX_ADDR_STATUS, rd);
        check_eq(32'(rd), 0, "status after ignored write");
        cfg_write(`SERDES_RX_ADDR_PATTERN, 16'(`SERDES_RX_PATTERN_RST));
        cfg_write(`SERDES_RX_ADDR_WAIT, 16'd4);
        cfg_write(`SERDES_RX_ADDR_CTRL, 16'd0);
        wait_locked();
    endtask

    task automatic raw_stream_test();
        serdes_rx_pkg::rx_word_t w;
        int i;
        cfg_write(`SERDES_RX_ADDR_CTRL, 16'd1);       // Enable, no alignment
        for (i = 0; i < 12; i++) begin
            w = 8'($urandom);
            exp_q.push_back(w);
            send_word(w);
        end
        cfg_write(`SERDES_RX_ADDR_CTRL, 16'd0);
        compare_stream();
    endtask

    task automatic alignment_test();
        serdes_rx_pkg::rx_word_t w;
        logic [15:0] rd;
        int k;
        int words;
        int i;
        k = 1 + int'($urandom % 7);
        skip_pattern = 1'b1;
        cfg_write(`SERDES_RX_ADDR_CTRL, 16'd3);       // Enable and align_en
        repeat (k) send_bit(1'($urandom));            // Shift the word boundary
        words = 0;
        while (!serdes_rx_top_i.aligned && words < 40) begin
            send_word(`SERDES_RX_PATTERN_RST);
            words++;
        end
        check_eq(32'(serdes_rx_top_i.aligned), 1, "aligned within 40 training words");
        for (i = 0; i < 10; i++) begin
            do begin
                w = 8'($urandom);
            end while (w == `SERDES_RX_PATTERN_RST);  // Data must differ from training
            exp_q.push_back(w);
            send_word(w);
        end
        cfg_write(`SERDES_RX_ADDR_CTRL, 16'd2);       // Stop sampling, stay aligned
        cfg_read(`SERDES_RX_ADDR_STATUS, rd);
        check_eq(32'(rd[ALIGNED_BIT]), 1, "aligned status bit");
        compare_stream();
        cfg_write(`SERDES_RX_ADDR_CTRL, 16'd0);
        skip_pattern = 1'b0;
    endtask

    task automatic back_pressure_test();
        serdes_rx_pkg::rx_word_t w;
        logic [15:0] rd;
        int i;
        out_ready = 1'b0;
        cfg_write(`SERDES_RX_ADDR_CTRL, 16'd1);
        for (i = 0; i < 6; i++) begin
            w = 8'($urandom);
            if (i < 2) begin
                exp_q.push_back(w);                   // Only two fit
            end
            send_word(w);
        end
        cfg_write(`SERDES_RX_ADDR_CTRL, 16'd0);
        repeat (4) @(negedge fabric_clk_div);         // Last word reaches the buffer
        cfg_read(`SERDES_RX_ADDR_STATUS, rd);
        check_eq(32'(rd[7:0]), 4, "drop count after stall");
        check_eq(rx_q.size(), 0, "transfers while out_ready low");
        out_ready = 1'b1;
        compare_stream();
        ready_random = 1'b1;
        drive_cycle = 0;
        cfg_write(`SERDES_RX_ADDR_CTRL, 16'd1);
        for (i = 0; i < 16; i++) begin
            w = 8'($urandom);
            exp_q.push_back(w);
            send_word(w);
        end
        ready_random = 1'b0;
        out_ready = 1'b1;
        cfg_write(`SERDES_RX_ADDR_CTRL, 16'd0);
        compare_stream();
        cfg_read(`SERDES_RX_ADDR_STATUS, rd);
        check_eq(32'(rd[7:0]), 4, "drop count after random out_ready");
    endtask

    task automatic enable_gate_test();
        serdes_rx_pkg::rx_word_t w;
        int i;
        for (i = 0; i < 24; i++) begin
            send_bit(1'($urandom));
            check_eq(32'(out_valid), 0, "out_valid with enable low");
        end
        check_eq(rx_q.size(), 0, "words received with enable low");
        cfg_write(`SERDES_RX_ADDR_CTRL, 16'd1);
        for (i = 0; i < 8; i++) begin
            w = 8'($urandom);
            exp_q.push_back(w);
            send_word(w);
        end
        cfg_write(`SERDES_RX_ADDR_CTRL, 16'd0);
        compare_stream();
    endtask

    // **************************************************
    // Sequence
    // **************************************************
    initial begin
        void'($urandom(57));
        reset_buf_n   = 1'b0;
        serial_data   = 1'b0;
        pll_lock      = 1'b0;
        cfg_req       = '0;
        cfg_req_valid = 1'b0;
        out_ready     = 1'b1;
        skip_pattern  = 1'b0;
        ready_random  = 1'b0;
        drive_cycle   = 0;
        apply_reset();
        lock_timing_test();
        register_access_test();
        raw_stream_test();
        alignment_test();
        back_pressure_test();
        enable_gate_test();
        $display("TEST PASSED");
        $finish;
    end

endmodule

// File: serdes_rx.f
+incdir+.
serdes_rx_pkg.sv
rx_deserializer.sv
rx_word_aligner.sv
rx_lock_sequencer.sv
rx_config_regs.sv
rx_skid_buffer.sv
serdes_rx_top.sv
tb_serdes_rx.sv

// File: Makefile
# Verilator flow for the serial receive front end
# Override any variable on the command line, e.g. make sim OBJ_DIR=build

VERILATOR ?= verilator
FILELIST  ?= serdes_rx.f
TOP       ?= tb_serdes_rx
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
